// File: logic/ic_config.svh
// ======================================================================
// Geometry of the instruction cache tag side. Line and way counts must
// be powers of two. Index and tag widths are derived in ic_addr_pkg,
// so only these four values change the cache shape.
// ======================================================================
`ifndef IC_CONFIG_SVH
`define IC_CONFIG_SVH

// Number of lines held in each way
`define IC_LINES 256

// Number of ways in a set
`define IC_WAYS 4

// Byte offset bits inside one line, 64 byte lines
`define IC_LOBIT 6

// Width of a byte code address
`define IC_ADDR_BITS 32

// With the values above the line index is address bits 13:6
// and the tag is address bits 31:14

`endif

// File: logic/ic_addr_pkg.sv
// ======================================================================
// Code address types for the cache tag side. Widths follow the macros
// of ic_config.svh, and the helpers split a byte address into its parts.
// ======================================================================
package ic_addr_pkg;

	`include "ic_config.svh"

	// Derived field widths and the top bit of the line index
	localparam int IC_INDEX_BITS = $clog2(`IC_LINES);
	localparam int IC_WAY_BITS   = $clog2(`IC_WAYS);
	localparam int IC_HIBIT      = `IC_LOBIT + IC_INDEX_BITS - 1;
	localparam int IC_TAG_BITS   = `IC_ADDR_BITS - IC_HIBIT - 1;

	typedef logic [`IC_ADDR_BITS-1:0] code_addr_t;
	typedef logic [IC_INDEX_BITS-1:0] ic_index_t;
	typedef logic [IC_TAG_BITS-1:0]   ic_tag_t;
	typedef logic [IC_WAY_BITS-1:0]   ic_way_t;
	// One bit per way, bit n stands for way n
	typedef logic [`IC_WAYS-1:0]      ic_way_mask_t;

	// Line index bits of a byte address
	function automatic ic_index_t addr_index(input code_addr_t addr);
		return addr[IC_HIBIT:`IC_LOBIT];
	endfunction

	// Tag bits of a byte address
	function automatic ic_tag_t addr_tag(input code_addr_t addr);
		return addr[`IC_ADDR_BITS-1:IC_HIBIT+1];
	endfunction

endpackage

// File: logic/ic_maint_pkg.sv
// ======================================================================
// Cache maintenance command word. The opcode sits in bits 31:30 in both
// views, so a decoder reads it before it picks the view to use.
// Reserved bits of the index view are ignored.
// ======================================================================
package ic_maint_pkg;

	import ic_addr_pkg::*;

	// Width of the word address carried by the address view
	localparam int IC_WORD_ADDR_BITS = $bits(code_addr_t) - 2;
	// Unused bits between opcode and way field in the index view
	localparam int IC_RSVD_BITS = IC_WORD_ADDR_BITS - IC_WAY_BITS - IC_INDEX_BITS;

	typedef enum logic [1:0] {
		NOP       = 2'd0,
		INV_ADDR  = 2'd1,
		INV_INDEX = 2'd2,
		INV_ALL   = 2'd3
	} maint_op_t;

	// Address view, the word address is the code address without its
	// two low byte bits
	typedef struct packed {
		maint_op_t                      op;
		logic [IC_WORD_ADDR_BITS-1:0]   word_addr;
	} maint_addr_view_t;

	// Index view names one way of one line directly
	typedef struct packed {
		maint_op_t                 op;
		logic [IC_RSVD_BITS-1:0]   rsvd;
		ic_way_t                   way;
		ic_index_t                 index;
	} maint_index_view_t;

	// The same 32-bit word seen through either view
	typedef union packed {
		maint_addr_view_t    addr;
		maint_index_view_t   idx;
	} maint_cmd_t;

endpackage

// File: logic/ic_if.sv
// ======================================================================
// Internal buses of the tag side. Maintenance actions run from the
// decoder to the valid array. Lookup results run from the stores to hit
// detection, and the top level drives the looked-up index.
// ======================================================================
`timescale 1ns/100ps
`include "ic_config.svh"

// Invalidate actions, inv_line and inv_all are one-cycle pulses
interface ic_maint_if import ic_addr_pkg::*; ();
	logic          inv_line;
	logic          inv_all;
	ic_index_t     inv_index;
	ic_way_mask_t  inv_ways;

	modport source (output inv_line, output inv_all, output inv_index, output inv_ways);
	modport sink   (input inv_line, input inv_all, input inv_index, input inv_ways);
endinterface

// State of one set as seen by the current fetch address
interface ic_lookup_if import ic_addr_pkg::*; ();
	ic_index_t                     look_index;
	ic_tag_t [`IC_WAYS-1:0]        way_tag;
	ic_way_mask_t                  way_valid;
	ic_tag_t                       ip_tag;

	// The tag store drives way_tag and ip_tag, the valid array drives
	// way_valid, both through this modport
	modport store (
		input  look_index,
		output way_tag,
		output way_valid,
		output ip_tag
	);

	modport compare (
		input way_tag,
		input way_valid,
		input ip_tag
	);
endinterface

// File: logic/ic_maint_decode.sv
// ======================================================================
// Maintenance command decoder. A command is registered once and turns
// into a single action pulse in the next cycle. Reserved opcode space
// does not exist, every encoding has a meaning.
// ======================================================================
`timescale 1ns/100ps

module ic_maint_decode import ic_addr_pkg::*; import ic_maint_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        cmd_valid,
	input  maint_cmd_t  cmd,
	ic_maint_if.source  maint
);

	maint_op_t     op;
	ic_index_t     next_index;
	ic_way_mask_t  next_ways;

	// The opcode field is shared by both views
	assign op = cmd.addr.op;

	// Pick the view from the opcode and build index and way mask
	always_comb begin
		next_index = cmd.idx.index;
		next_ways  = '1;
		case (op)
			INV_ADDR: begin
				// Rebuild the byte address to find its line, every way is hit
				next_index = addr_index({cmd.addr.word_addr, 2'b00});
				next_ways  = '1;
			end
			INV_INDEX: begin
				next_index = cmd.idx.index;
				next_ways  = ic_way_mask_t'(1) << cmd.idx.way;
			end
			default: begin
				next_index = cmd.idx.index;
				next_ways  = '1;
			end
		endcase
	end

	// Action pulses, low out of reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			maint.inv_line <= 1'b0;
			maint.inv_all  <= 1'b0;
		end else begin
			maint.inv_line <= cmd_valid && (op == INV_ADDR || op == INV_INDEX);
			maint.inv_all  <= cmd_valid && (op == INV_ALL);
		end
	end

	// Target of the action, only meaningful while a pulse is high
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			maint.inv_index <= next_index;
			maint.inv_ways  <= next_ways;
		end
	end

	// The valid array treats the two pulses as exclusive
	a_one_action: assert property (@(posedge clk) disable iff (rst)
		!(maint.inv_line && maint.inv_all));

endmodule

// File: logic/ic_valid_array.sv
// ======================================================================
// Valid bits of every way and line. A fill sets one bit and wins over
// an invalidate in the same cycle, which is then lost. All bits clear
// on reset.
// ======================================================================
`timescale 1ns/100ps
`include "ic_config.svh"

module ic_valid_array import ic_addr_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        fill,
	input  ic_way_t     fill_way,
	input  ic_index_t   fill_index,
	ic_maint_if.sink    maint,
	ic_lookup_if.store  look
);

	// One bit per line, one vector per way
	logic [`IC_LINES-1:0] valid_bits [`IC_WAYS];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int w = 0; w < `IC_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else if (fill) begin
			valid_bits[fill_way][fill_index] <= 1'b1;
		end else if (maint.inv_line) begin
			// Clear only the ways named in the mask
			for (int w = 0; w < `IC_WAYS; w++) begin
				if (maint.inv_ways[w]) begin
					valid_bits[w][maint.inv_index] <= 1'b0;
				end
			end
		end else if (maint.inv_all) begin
			for (int w = 0; w < `IC_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end
	end

	// Valid bits of the set under lookup
	always_comb begin
		for (int w = 0; w < `IC_WAYS; w++) begin
			look.way_valid[w] = valid_bits[w][look.look_index];
		end
	end

	// A line invalidate from the decoder always names at least one way
	a_mask_nonempty: assert property (@(posedge clk) disable iff (rst)
		maint.inv_line |-> (maint.inv_ways != '0));

endmodule

// File: logic/ic_tag_store.sv
// ======================================================================
// Tag registers of every way and line. Contents are undefined until a
// fill, the valid bits decide whether a tag counts.
// ======================================================================
`timescale 1ns/100ps
`include "ic_config.svh"

module ic_tag_store import ic_addr_pkg::*; (
	input  logic        clk,
	input  logic        fill,
	input  ic_way_t     fill_way,
	input  code_addr_t  ip,
	ic_lookup_if.store  look
);

	ic_tag_t tags [`IC_WAYS][`IC_LINES];
	ic_index_t ip_index;

	// Fills always use the line of the current fetch address
	assign ip_index = addr_index(ip);

	// Write the fetch tag into the chosen way
	always_ff @(posedge clk) begin
		if (fill) begin
			tags[fill_way][ip_index] <= addr_tag(ip);
		end
	end

	// Tag the lookup is compared against
	assign look.ip_tag = addr_tag(ip);

	// Stored tags of all ways at the looked-up line
	always_comb begin
		for (int w = 0; w < `IC_WAYS; w++) begin
			look.way_tag[w] = tags[w][look.look_index];
		end
	end

endmodule

// File: logic/ic_hit_detect.sv
// ======================================================================
// Tag compare and hit register. Results appear one cycle after the
// fetch address. hit_way reads zero whenever hit is low.
// ======================================================================
`timescale 1ns/100ps
`include "ic_config.svh"

module ic_hit_detect import ic_addr_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	ic_lookup_if.compare  look,
	output logic          hit,
	output ic_way_t       hit_way
);

	ic_way_mask_t  match;
	ic_way_t       match_way;

	// A way matches only when its tag is equal and its line is valid
	always_comb begin
		for (int w = 0; w < `IC_WAYS; w++) begin
			match[w] = look.way_valid[w] && (look.way_tag[w] == look.ip_tag);
		end
	end

	// Encode the matching way, at most one bit is set
	always_comb begin
		match_way = '0;
		for (int w = 0; w < `IC_WAYS; w++) begin
			if (match[w]) begin
				match_way = ic_way_t'(w);
			end
		end
	end

	// ==================================================================
	// Result registers
	// ==================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit     <= 1'b0;
			hit_way <= '0;
		end else begin
			hit     <= |match;
			hit_way <= match_way;
		end
	end

	// Fills only on a miss keep one tag out of two ways of a line
	a_single_match: assert property (@(posedge clk) disable iff (rst)
		$onehot0(match));

endmodule

// File: logic/ic_lookup_top.sv
// ======================================================================
// Tag and valid side of a four way instruction cache. Fill only on a
// miss and pick the way outside. Maintenance takes two cycles to land.
// ======================================================================
`timescale 1ns/100ps

module ic_lookup_top import ic_addr_pkg::*; import ic_maint_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  code_addr_t  ip,
	input  logic        fill,
	input  ic_way_t     fill_way,
	input  logic        cmd_valid,
	input  maint_cmd_t  cmd,
	output logic        hit,
	output ic_way_t     hit_way
);

	ic_maint_if  maint_bus ();
	ic_lookup_if look_bus ();

	// Every cycle looks up the line of the fetch address
	assign look_bus.look_index = addr_index(ip);

	// Maintenance commands become invalidate actions
	ic_maint_decode u_ic_maint_decode (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.maint     (maint_bus.source)
	);

	// Valid bits, filled at the line of the fetch address
	ic_valid_array u_ic_valid_array (
		.clk        (clk),
		.rst        (rst),
		.fill       (fill),
		.fill_way   (fill_way),
		.fill_index (addr_index(ip)),
		.maint      (maint_bus.sink),
		.look       (look_bus.store)
	);

	ic_tag_store u_ic_tag_store (
		.clk      (clk),
		.fill     (fill),
		.fill_way (fill_way),
		.ip       (ip),
		.look     (look_bus.store)
	);

	ic_hit_detect u_ic_hit_detect (
		.clk     (clk),
		.rst     (rst),
		.look    (look_bus.compare),
		.hit     (hit),
		.hit_way (hit_way)
	);

endmodule

// File: testbench/tb_ic_lookup.sv
// ======================================================================
// Testbench for the cache tag side. A reference model of valid bits and
// tags predicts hit and hit_way for every cycle. Inputs change on the
// falling edge and outputs are sampled there too.
// ======================================================================
`timescale 1ns/100ps
`include "ic_config.svh"

module tb_ic_lookup import ic_addr_pkg::*; import ic_maint_pkg::*; ();

	localparam int RESET_CYCLES    = 8;
	localparam int DIRECTED_CYCLES = 64;
	localparam int RAND_CYCLES     = 3000;
	// Every step is one clock, the margin covers the last few edges
	localparam int MAX_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 50;

	logic        clk;
	logic        rst;
	code_addr_t  ip;
	logic        fill;
	ic_way_t     fill_way;
	logic        cmd_valid;
	maint_cmd_t  cmd;
	logic        hit;
	ic_way_t     hit_way;

	integer seed = 32'h409d_2d51;
	int cycles = 0;
	int hit_count = 0;

	// Reference state, one valid vector and one tag table per way
	bit [`IC_LINES-1:0] m_valid [`IC_WAYS];
	ic_tag_t            m_tag [`IC_WAYS][`IC_LINES];
	// Command registered by the decoder and waiting for the next edge
	bit                 pend_line;
	bit                 pend_all;
	ic_index_t          pend_index;
	ic_way_mask_t       pend_ways;

	// Small pools so that lines are reused and tags collide in a set
	ic_tag_t   tag_pool [8] = '{18'h00001, 18'h2abcd, 18'h13579, 18'h3ffff,
		18'h0f0f0, 18'h10000, 18'h00fff, 18'h25a5a};
	ic_index_t idx_pool [4] = '{8'h00, 8'h5a, 8'ha5, 8'hff};

	ic_lookup_top u_ic_lookup_top (
		.clk       (clk),
		.rst       (rst),
		.ip        (ip),
		.fill      (fill),
		.fill_way  (fill_way),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.hit       (hit),
		.hit_way   (hit_way)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Watchdog on the total number of rising edges
	initial begin
		while (cycles <= MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		report_failure("Timeout, the run went past its cycle limit");
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "Test stopped at cycle %0d", cycles);
	endtask

	task automatic check_hit(input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("ERR hit: got %h, expected %h, ip %h", actual, expected, ip);
			report_failure("Hit flag differs from the model");
		end
	endtask

	task automatic check_way(input ic_way_t actual, input ic_way_t expected);
		if (actual !== expected) begin
			$display("ERR hit_way: got %h, expected %h, ip %h", actual, expected, ip);
			report_failure("Hit way differs from the model");
		end
	endtask

	// Line index is byte address bits 13:6, the tag is bits 31:14
	function automatic ic_index_t line_of(input code_addr_t a);
		return a[13:6];
	endfunction

	function automatic ic_tag_t tag_of(input code_addr_t a);
		return a[31:14];
	endfunction

	// Miss reports way zero
	task automatic model_lookup(input code_addr_t a, output logic h, output ic_way_t w);
		h = 1'b0;
		w = '0;
		for (int i = 0; i < `IC_WAYS; i++) begin
			if (m_valid[i][line_of(a)] && m_tag[i][line_of(a)] == tag_of(a)) begin
				h = 1'b1;
				w = ic_way_t'(i);
			end
		end
	endtask

	// State change at one rising edge. A fill drops the action due there
	task automatic model_edge(input code_addr_t a, input logic f, input ic_way_t fw,
		input logic cv, input logic [31:0] cw);
		code_addr_t target;
		if (f) begin
			m_valid[fw][line_of(a)] = 1'b1;
			m_tag[fw][line_of(a)]   = tag_of(a);
		end else if (pend_line) begin
			for (int i = 0; i < `IC_WAYS; i++) begin
				if (pend_ways[i])
					m_valid[i][pend_index] = 1'b0;
			end
		end else if (pend_all) begin
			for (int i = 0; i < `IC_WAYS; i++)
				m_valid[i] = '0;
		end
		// Opcode 1 is by address, 2 by way and index, 3 everything
		pend_line = cv && (cw[31:30] == 2'd1 || cw[31:30] == 2'd2);
		pend_all  = cv && (cw[31:30] == 2'd3);
		if (cv && cw[31:30] == 2'd1) begin
			target     = {cw[29:0], 2'b00};
			pend_index = line_of(target);
			pend_ways  = '1;
		end else if (cv) begin
			pend_index = cw[7:0];
			pend_ways  = ic_way_mask_t'(1) << cw[9:8];
		end
	endtask

	// One clock: drive, predict, advance and compare
	task automatic step(input code_addr_t a, input logic f, input ic_way_t fw,
		input logic cv, input logic [31:0] cw);
		logic    exp_hit;
		ic_way_t exp_way;
		ip        = a;
		fill      = f;
		fill_way  = fw;
		cmd_valid = cv;
		cmd       = cw;
		model_lookup(a, exp_hit, exp_way);
		model_edge(a, f, fw, cv, cw);
		@(posedge clk);
		@(negedge clk);
		if (exp_hit)
			hit_count++;
		check_hit(hit, exp_hit);
		check_way(hit_way, exp_way);
	endtask

	task automatic lookup_only(input code_addr_t a);
		step(a, 1'b0, '0, 1'b0, '0);
	endtask

	task automatic fill_line(input code_addr_t a, input ic_way_t w);
		logic    h;
		ic_way_t hw;
		model_lookup(a, h, hw);
		if (h)
			report_failure("Directed fill aimed at an address that already hits");
		step(a, 1'b1, w, 1'b0, '0);
	endtask

	task automatic send_cmd(input code_addr_t a, input logic [31:0] cw);
		step(a, 1'b0, '0, 1'b1, cw);
	endtask

	function automatic logic [31:0] inv_addr_word(input code_addr_t a);
		return {2'b01, a[31:2]};
	endfunction

	function automatic logic [31:0] inv_index_word(input ic_way_t w, input ic_index_t idx);
		return {2'b10, 20'd0, w, idx};
	endfunction

	function automatic code_addr_t pool_addr();
		logic [31:0] r;
		r = $random(seed);
		return {tag_pool[r[2:0]], idx_pool[r[4:3]], r[10:5]};
	endfunction

	// ==================================================================
	// Test sequence
	// ==================================================================
	initial begin
		code_addr_t  a_addr, b_addr, c_addr, d_addr, e_addr, ra;
		logic [31:0] r;
		logic [31:0] cw;
		logic        h, do_fill;
		ic_way_t     hw;
		int          start_hits;

		// Same index for A and B, C to E on other lines
		a_addr = {18'h2abcd, 8'h5a, 6'h10};
		b_addr = {18'h13579, 8'h5a, 6'h00};
		c_addr = {18'h00001, 8'ha5, 6'h3c};
		d_addr = {18'h3ffff, 8'h00, 6'h04};
		e_addr = {18'h0f0f0, 8'hff, 6'h20};
		rst = 1'b1;
		ip = '0;
		fill = 1'b0;
		fill_way = '0;
		cmd_valid = 1'b0;
		cmd = '0;
		for (int i = 0; i < `IC_WAYS; i++)
			m_valid[i] = '0;
		pend_line = 1'b0;
		pend_all  = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// Empty cache misses everywhere
		lookup_only(a_addr);
		lookup_only(b_addr);
		lookup_only(c_addr);
		lookup_only(d_addr);

		// Fill then hit, a second tag in the set misses
		fill_line(a_addr, 2'd2);
		lookup_only(a_addr);
		lookup_only(b_addr);

		// Invalidate by address clears the whole set
		fill_line(b_addr, 2'd0);
		lookup_only(a_addr);
		lookup_only(b_addr);
		send_cmd(a_addr, inv_addr_word(a_addr ^ 32'h24));
		lookup_only(c_addr);
		lookup_only(a_addr);
		lookup_only(b_addr);

		// Invalidate by index takes one way, the neighbor keeps hitting
		fill_line(a_addr, 2'd1);
		fill_line(b_addr, 2'd3);
		send_cmd(a_addr, inv_index_word(2'd1, 8'h5a));
		lookup_only(c_addr);
		lookup_only(a_addr);
		lookup_only(b_addr);

		// Invalidate all, then an invalidate that collides with a fill
		fill_line(c_addr, 2'd0);
		send_cmd(c_addr, {2'b11, 30'd0});
		lookup_only(c_addr);
		lookup_only(b_addr);
		lookup_only(c_addr);
		fill_line(e_addr, 2'd1);
		send_cmd(e_addr, {2'b11, 30'd0});
		fill_line(d_addr, 2'd2);
		lookup_only(d_addr);
		lookup_only(e_addr);

		// Random mix of lookups, fills on a miss and commands
		start_hits = hit_count;
		for (int n = 0; n < RAND_CYCLES; n++) begin
			ra = pool_addr();
			model_lookup(ra, h, hw);
			r = $random(seed);
			do_fill = !h && (r[1:0] == 2'd0);
			case (r[6:5])
				2'd0: cw = {2'b00, r[29:0]};
				2'd1: cw = inv_addr_word(pool_addr());
				2'd2: cw = inv_index_word(r[8:7], idx_pool[r[10:9]]);
				default: cw = {2'b11, 30'd0};
			endcase
			// Clear-all stays rare so the sets can fill up
			if (r[6:5] == 2'd3 && r[13:11] != 3'd0)
				cw = inv_addr_word(pool_addr());
			step(ra, do_fill, r[15:14], r[19:16] == 4'd0, cw);
		end

		if (hit_count == start_hits) begin
			report_failure("Random phase never produced a hit");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

// File: compile.f
+incdir+logic
logic/ic_addr_pkg.sv
logic/ic_maint_pkg.sv
logic/ic_if.sv
logic/ic_maint_decode.sv
logic/ic_valid_array.sv
logic/ic_tag_store.sv
logic/ic_hit_detect.sv
logic/ic_lookup_top.sv
testbench/tb_ic_lookup.sv

// File: Bender.yml
package:
  name: ic_lookup

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/ic_addr_pkg.sv
      - logic/ic_maint_pkg.sv
      - logic/ic_if.sv
      - logic/ic_maint_decode.sv
      - logic/ic_valid_array.sv
      - logic/ic_tag_store.sv
      - logic/ic_hit_detect.sv
      - logic/ic_lookup_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/tb_ic_lookup.sv
